//--- ninjin_pkg.sv
`default_nettype none

package ninjin_pkg;

  // Default geometry of the write-back path.
  localparam int DWIDTH_DEF    = 16;  // Core word width.
  localparam int BWIDTH_DEF    = 64;  // DDR beat width.
  localparam int BURST_LEN_DEF = 8;   // Beats per ping-pong buffer.
  localparam int IMGSIZE_DEF   = 12;  // Word address width.
  localparam int LWIDTH_DEF    = 16;  // Width of the total word count.

  // Relation of a write to the one before it.
  typedef enum logic [1:0] {
    S_IDLE,   // No write this cycle.
    S_INCR,   // Previous address plus one.
    S_TRANS   // First write of a job, or a jump.
  } step_t;

  // Life cycle of one ping-pong buffer.
  typedef enum logic [1:0] {
    BUF_FILL,   // Receiving beats from the packer.
    BUF_FULL,   // Closed, waiting for its request.
    BUF_DRAIN,  // Being read by the DDR master.
    BUF_FREE    // Empty.
  } buf_state_t;

endpackage

`default_nettype wire

//--- mem_sp.sv
`default_nettype none

module mem_sp #(
  parameter int WIDTH  = 64,
  parameter int AWIDTH = 3
) (
  input  logic              clk,
  input  logic              we,
  input  logic [AWIDTH-1:0] addr,
  input  logic [WIDTH-1:0]  wdata,
  output logic [WIDTH-1:0]  rdata
);

  localparam int DEPTH = 2 ** AWIDTH;

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // One cycle read latency.
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

//--- ninjin_pack.sv
`default_nettype none

module ninjin_pack #(
  parameter int DWIDTH  = ninjin_pkg::DWIDTH_DEF,
  parameter int BWIDTH  = ninjin_pkg::BWIDTH_DEF,
  parameter int IMGSIZE = ninjin_pkg::IMGSIZE_DEF,
  parameter int LWIDTH  = ninjin_pkg::LWIDTH_DEF
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic [LWIDTH-1:0]        total_len,
  input  logic                     mem_we,
  input  logic [IMGSIZE-1:0]       mem_addr,
  input  logic signed [DWIDTH-1:0] mem_wdata,
  output logic                     beat_we,
  output logic [BWIDTH-1:0]        beat_data,
  output logic                     beat_first,
  output logic                     beat_last,
  output logic [IMGSIZE-1:0]       beat_base
);

  import ninjin_pkg::*;

  localparam int RATE  = BWIDTH / DWIDTH;
  localparam int LANEW = $clog2(RATE);

  step_t                   step;
  logic                    final_word;  // This write reaches total_len.
  logic                    r_started;
  logic [LWIDTH-1:0]       r_cnt;
  logic [IMGSIZE-1:0]      r_prev;

  step_t                   r_step;
  logic                    r_final;
  logic [IMGSIZE-1:0]      r_addr;
  logic signed [DWIDTH-1:0] r_wdata;

  logic [LANEW-1:0]        r_lane;      // Words already in the partial beat.
  logic [BWIDTH-1:0]       r_part;
  logic                    r_pfirst;    // Partial beat opens its burst.
  logic [IMGSIZE-1:0]      r_base;      // Address of the partial beat's first word.
  logic                    r_tail;      // Lone final word still to send.
  logic [LANEW-1:0]        lane;
  logic [BWIDTH-1:0]       merged;
  logic                    flush;
  logic                    emit_incr;

  always_comb begin
    if (!mem_we)
      step = S_IDLE;
    else if (!r_started || mem_addr != r_prev + IMGSIZE'(1))
      step = S_TRANS;
    else
      step = S_INCR;
  end

  assign final_word = mem_we && (r_cnt + LWIDTH'(1) == total_len);

  // Word count; the job restarts after the last word.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_started <= 1'b0;
      r_cnt     <= '0;
    end else if (mem_we) begin
      r_started <= !final_word;
      r_cnt     <= final_word ? '0 : r_cnt + LWIDTH'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      r_prev <= mem_addr;
    end
  end

  // Input register stage.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_step  <= S_IDLE;
      r_final <= 1'b0;
    end else begin
      r_step  <= step;
      r_final <= final_word;
    end
  end

  always_ff @(posedge clk) begin
    r_addr  <= mem_addr;
    r_wdata <= mem_wdata;
  end

  // A jump starts the new word in lane 0 of an empty beat.
  always_comb begin
    lane   = (r_step == S_TRANS) ? '0 : r_lane;
    merged = (r_step == S_TRANS) ? '0 : r_part;
    merged[lane*DWIDTH +: DWIDTH] = r_wdata;
  end

  assign flush     = r_step == S_TRANS && r_lane != '0;
  assign emit_incr = r_step == S_INCR && (r_lane == LANEW'(RATE - 1) || r_final);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      beat_we    <= 1'b0;
      beat_first <= 1'b0;
      beat_last  <= 1'b0;
      r_lane     <= '0;
      r_pfirst   <= 1'b0;
      r_tail     <= 1'b0;
    end else begin
      beat_we <= 1'b0;
      r_tail  <= 1'b0;
      if (r_tail) begin
        beat_we    <= 1'b1;
        beat_first <= 1'b1;
        beat_last  <= 1'b1;
        r_lane     <= '0;
        r_pfirst   <= 1'b0;
      end else if (r_step == S_TRANS) begin
        beat_we    <= flush || r_final;  // Old partial beat, or a one-word job end.
        beat_first <= flush ? r_pfirst : 1'b1;
        beat_last  <= 1'b1;
        r_tail     <= flush && r_final;
        r_lane     <= (r_final && !flush) ? '0 : LANEW'(1);
        r_pfirst   <= !(r_final && !flush);
      end else if (emit_incr) begin
        beat_we    <= 1'b1;
        beat_first <= r_pfirst;
        beat_last  <= r_final;
        r_lane     <= '0;
        r_pfirst   <= 1'b0;
      end else if (r_step == S_INCR) begin
        r_lane <= r_lane + LANEW'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (r_tail) begin
      beat_data <= r_part;
      beat_base <= r_base;
    end else begin
      beat_data <= flush ? r_part : merged;
      beat_base <= (r_step == S_TRANS && !flush) ? r_addr : r_base;
    end
    if (r_step == S_TRANS) begin
      r_part <= merged;
      r_base <= r_addr;  // New burst base.
    end else if (r_step == S_INCR) begin
      r_part <= emit_incr ? '0 : merged;  // Empty lanes stay zero.
      if (emit_incr) begin
        r_base <= r_addr + IMGSIZE'(1);  // Next beat starts at the following word.
      end
    end
  end

endmodule

`default_nettype wire

//--- ninjin_ddr_buf.sv
`default_nettype none

module ninjin_ddr_buf #(
  parameter int    BWIDTH    = ninjin_pkg::BWIDTH_DEF,
  parameter int    BURST_LEN = ninjin_pkg::BURST_LEN_DEF,
  parameter int    IMGSIZE   = ninjin_pkg::IMGSIZE_DEF,
  localparam int   AWIDTH    = $clog2(BURST_LEN),
  localparam int   LENW      = $clog2(BURST_LEN + 1)
) (
  input  logic               clk,
  input  logic               xrst,
  input  logic               beat_we,
  input  logic [BWIDTH-1:0]  beat_data,
  input  logic               beat_first,
  input  logic               beat_last,
  input  logic [IMGSIZE-1:0] beat_base,
  input  logic               ddr_re,
  input  logic [AWIDTH-1:0]  ddr_addr,
  output logic               mem_ready,
  output logic               ddr_req,
  output logic [IMGSIZE-1:0] ddr_base,
  output logic [LENW-1:0]    ddr_len,
  output logic [BWIDTH-1:0]  ddr_wdata
);

  import ninjin_pkg::*;

  buf_state_t         r_state [2];
  logic [LENW-1:0]    r_len [2];      // Beats written, later the burst length.
  logic [IMGSIZE-1:0] r_base [2];
  logic               r_turn;         // Buffer being filled.
  logic               r_dsel;         // Oldest closed buffer, next to drain.
  logic               r_rsel;         // Buffer read in the previous cycle.

  step_t              beat_step;
  logic               split;
  logic               dst;
  logic [LENW-1:0]    widx;
  logic               seal_dst;
  logic               drain_last;
  logic [1:0]         fill_we;
  logic [1:0]         seal;
  logic [AWIDTH-1:0]  buf_addr [2];
  logic [BWIDTH-1:0]  buf_rdata [2];

  always_comb begin
    if (!beat_we)
      beat_step = S_IDLE;
    else if (beat_first)
      beat_step = S_TRANS;
    else
      beat_step = S_INCR;
  end

  // A new burst while the fill buffer still holds beats closes that buffer
  // and lands in the other one.
  assign split      = beat_step == S_TRANS && r_len[r_turn] != '0;
  assign dst        = r_turn ^ split;
  assign widx       = split ? '0 : r_len[r_turn];
  assign seal_dst   = beat_last || widx == LENW'(BURST_LEN - 1);
  assign drain_last = ddr_re && LENW'(ddr_addr) == r_len[r_dsel] - LENW'(1);

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      fill_we[i] = beat_step != S_IDLE && dst == 1'(i);
      seal[i]    = (split && r_turn == 1'(i)) || (fill_we[i] && seal_dst);
      // Fill side owns the address until the buffer is closed.
      if (r_state[i] == BUF_FREE || r_state[i] == BUF_FILL)
        buf_addr[i] = widx[AWIDTH-1:0];
      else
        buf_addr[i] = ddr_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_turn <= 1'b0;
      r_dsel <= 1'b0;
    end else begin
      if (beat_step != S_IDLE) begin
        r_turn <= r_turn ^ split ^ seal_dst;  // One flip per closed buffer.
      end
      if (drain_last) begin
        r_dsel <= ~r_dsel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ddr_re) begin
      r_rsel <= r_dsel;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < 2; i++) begin
        r_state[i] <= BUF_FREE;
        r_len[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (drain_last && r_dsel == 1'(i)) begin
          r_state[i] <= BUF_FREE;  // Last beat read.
          r_len[i]   <= '0;
        end else if (ddr_req && r_dsel == 1'(i)) begin
          r_state[i] <= BUF_DRAIN;
        end else begin
          if (seal[i])
            r_state[i] <= BUF_FULL;
          else if (fill_we[i])
            r_state[i] <= BUF_FILL;
          if (fill_we[i]) begin
            r_len[i] <= widx + LENW'(1);
          end
        end
      end
    end
  end

  // The first beat in a buffer sets the burst base.
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (fill_we[i] && widx == '0) begin
        r_base[i] <= beat_base;
      end
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_buf
    mem_sp #(
      .WIDTH  (BWIDTH),
      .AWIDTH (AWIDTH)
    ) mem_buf (
      .clk   (clk),
      .we    (fill_we[i]),
      .addr  (buf_addr[i]),
      .wdata (beat_data),
      .rdata (buf_rdata[i])
    );
  end

  // Requests go out in fill order, one drain at a time.
  assign ddr_req   = r_state[r_dsel] == BUF_FULL;
  assign ddr_base  = r_base[r_dsel];
  assign ddr_len   = r_len[r_dsel];
  assign ddr_wdata = buf_rdata[r_rsel];

  // Up to three beats can still land after mem_ready drops, so the fill
  // buffer must keep that much room unless the next buffer is free.
  assign mem_ready = (r_state[r_turn] == BUF_FREE || r_state[r_turn] == BUF_FILL)
                  && (r_state[~r_turn] == BUF_FREE
                      || r_len[r_turn] < LENW'(BURST_LEN - 3));

endmodule

`default_nettype wire

//--- ninjin_top.sv
`default_nettype none

module ninjin_top #(
  parameter int  DWIDTH    = ninjin_pkg::DWIDTH_DEF,
  parameter int  BWIDTH    = ninjin_pkg::BWIDTH_DEF,
  parameter int  BURST_LEN = ninjin_pkg::BURST_LEN_DEF,
  parameter int  IMGSIZE   = ninjin_pkg::IMGSIZE_DEF,
  parameter int  LWIDTH    = ninjin_pkg::LWIDTH_DEF,
  localparam int AWIDTH    = $clog2(BURST_LEN),
  localparam int LENW      = $clog2(BURST_LEN + 1)
) (
  input  wire                     clk,
  input  wire                     xrst,
  input  wire [LWIDTH-1:0]        total_len,
  input  wire                     mem_we,
  input  wire [IMGSIZE-1:0]       mem_addr,
  input  wire signed [DWIDTH-1:0] mem_wdata,
  output wire                     mem_ready,
  output wire                     ddr_req,
  output wire [IMGSIZE-1:0]       ddr_base,
  output wire [LENW-1:0]          ddr_len,
  input  wire                     ddr_re,
  input  wire [AWIDTH-1:0]        ddr_addr,
  output wire [BWIDTH-1:0]        ddr_wdata
);

  // Packer to buffer controller.
  wire               beat_we;
  wire [BWIDTH-1:0]  beat_data;
  wire               beat_first;
  wire               beat_last;
  wire [IMGSIZE-1:0] beat_base;

  ninjin_pack #(
    .DWIDTH  (DWIDTH),
    .BWIDTH  (BWIDTH),
    .IMGSIZE (IMGSIZE),
    .LWIDTH  (LWIDTH)
  ) pack0 (
    .clk        (clk),
    .xrst       (xrst),
    .total_len  (total_len),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .beat_we    (beat_we),
    .beat_data  (beat_data),
    .beat_first (beat_first),
    .beat_last  (beat_last),
    .beat_base  (beat_base)
  );

  ninjin_ddr_buf #(
    .BWIDTH    (BWIDTH),
    .BURST_LEN (BURST_LEN),
    .IMGSIZE   (IMGSIZE)
  ) buf0 (
    .clk        (clk),
    .xrst       (xrst),
    .beat_we    (beat_we),
    .beat_data  (beat_data),
    .beat_first (beat_first),
    .beat_last  (beat_last),
    .beat_base  (beat_base),
    .ddr_re     (ddr_re),
    .ddr_addr   (ddr_addr),
    .mem_ready  (mem_ready),
    .ddr_req    (ddr_req),
    .ddr_base   (ddr_base),
    .ddr_len    (ddr_len),
    .ddr_wdata  (ddr_wdata)
  );

endmodule

`default_nettype wire

//--- tb_ninjin_asserts.sv
`default_nettype none

module tb_ninjin_asserts #(
  parameter int  BURST_LEN = ninjin_pkg::BURST_LEN_DEF,
  localparam int LENW      = $clog2(BURST_LEN + 1)
) (
  input logic                  clk,
  input logic                  xrst,
  input logic                  ddr_req,
  input logic [LENW-1:0]       ddr_len,
  input ninjin_pkg::buf_state_t state0,
  input ninjin_pkg::buf_state_t state1
);

  import ninjin_pkg::*;

  // The requested buffer moves to drain on the next edge.
  req_pulse: assert property (@(posedge clk) disable iff (!xrst)
    ddr_req |=> !ddr_req)
    else $error("ddr_req stayed high for more than one cycle");

  req_not_in_drain: assert property (@(posedge clk) disable iff (!xrst)
    ddr_req |-> (state0 != BUF_DRAIN && state1 != BUF_DRAIN))
    else $error("ddr_req raised while a drain was still in progress");

  len_in_range: assert property (@(posedge clk) disable iff (!xrst)
    ddr_req |-> (ddr_len != '0 && ddr_len <= LENW'(BURST_LEN)))
    else $error("ddr_len outside of one to BURST_LEN beats");

  // First cycle out of reset.
  reset_clean: assert property (@(posedge clk)
    $rose(xrst) |-> (state0 == BUF_FREE && state1 == BUF_FREE && !ddr_req))
    else $error("buffers not free or ddr_req high after reset");

endmodule

`default_nettype wire

//--- tb_ninjin.sv
`default_nettype none

module tb_ninjin;

  import ninjin_pkg::*;

  localparam int DWIDTH      = DWIDTH_DEF;
  localparam int BWIDTH      = BWIDTH_DEF;
  localparam int BURST_LEN   = BURST_LEN_DEF;
  localparam int IMGSIZE     = IMGSIZE_DEF;
  localparam int LWIDTH      = LWIDTH_DEF;
  localparam int RATE        = BWIDTH / DWIDTH;
  localparam int AWIDTH      = $clog2(BURST_LEN);
  localparam int LENW        = $clog2(BURST_LEN + 1);
  localparam int FULL_RUN    = 2 * BURST_LEN * RATE;  // Two full bursts.
  localparam int JUMP_A      = RATE + 2;              // Ends two words into a beat.
  localparam int JUMP_B      = 3 * RATE + 1;
  localparam int TAIL_RUN    = 2 * RATE + 1;
  localparam int TOTAL_WORDS = FULL_RUN + JUMP_A + JUMP_B + FULL_RUN + TAIL_RUN;
  // Worst drain is 21 wait cycles plus two per beat, far below 24 per word.
  localparam int CYCLE_LIMIT = TOTAL_WORDS * 24 + 1000;

  logic                      clk = 1'b0;
  logic                      xrst;
  logic [LWIDTH-1:0]         total_len;
  logic                      mem_we;
  logic [IMGSIZE-1:0]        mem_addr;
  logic signed [DWIDTH-1:0]  mem_wdata;
  logic                      mem_ready;
  logic                      ddr_req;
  logic [IMGSIZE-1:0]        ddr_base;
  logic [LENW-1:0]           ddr_len;
  logic                      ddr_re;
  logic [AWIDTH-1:0]         ddr_addr;
  logic [BWIDTH-1:0]         ddr_wdata;

  // Expected bursts, oldest first.
  logic [IMGSIZE-1:0]        exp_base [$];
  logic [LENW-1:0]           exp_len [$];
  logic [BWIDTH-1:0]         exp_beats [$];

  // Reference packer state.
  logic [BWIDTH-1:0]         m_beat = '0;
  int                        m_lane = 0;
  int                        m_nbeats = 0;
  logic [IMGSIZE-1:0]        m_base;
  logic [IMGSIZE-1:0]        m_prev;
  bit                        m_started = 1'b0;

  bit                        draining = 1'b0;
  bit                        saw_stall = 1'b0;
  int                        cycles = 0;

  always #10 clk = ~clk;

  ninjin_top #(
    .DWIDTH    (DWIDTH),
    .BWIDTH    (BWIDTH),
    .BURST_LEN (BURST_LEN),
    .IMGSIZE   (IMGSIZE),
    .LWIDTH    (LWIDTH)
  ) dut0 (
    .clk       (clk),
    .xrst      (xrst),
    .total_len (total_len),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .ddr_req   (ddr_req),
    .ddr_base  (ddr_base),
    .ddr_len   (ddr_len),
    .ddr_re    (ddr_re),
    .ddr_addr  (ddr_addr),
    .ddr_wdata (ddr_wdata)
  );

  bind ninjin_ddr_buf tb_ninjin_asserts #(.BURST_LEN(BURST_LEN)) asserts0 (
    .clk     (clk),
    .xrst    (xrst),
    .ddr_req (ddr_req),
    .ddr_len (ddr_len),
    .state0  (r_state[0]),
    .state1  (r_state[1])
  );

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic report_mismatch(input string name, input logic [BWIDTH-1:0] exp,
                                 input logic [BWIDTH-1:0] got);
    $display("ERROR: time %0t, %s expected %h, got %h", $time, name, exp, got);
    abort_run();
  endtask

  task automatic push_beat();
    exp_beats.push_back(m_beat);
    m_beat = '0;  // Unfilled lanes read as zero.
    m_lane = 0;
    m_nbeats++;
  endtask

  task automatic push_burst();
    exp_base.push_back(m_base);
    exp_len.push_back(LENW'(m_nbeats));
    m_base   = m_base + IMGSIZE'(BURST_LEN * RATE);
    m_nbeats = 0;
  endtask

  task automatic close_burst();
    if (m_lane != 0)
      push_beat();
    if (m_nbeats != 0)
      push_burst();
  endtask

  task automatic model_word(input logic [IMGSIZE-1:0] addr, input logic [DWIDTH-1:0] data,
                            input bit last);
    if (!m_started || addr != m_prev + IMGSIZE'(1)) begin
      close_burst();  // A jump or a new job ends the open burst.
      m_base = addr;
    end
    m_beat[m_lane*DWIDTH +: DWIDTH] = data;  // Earliest word in the low lane.
    m_lane++;
    if (m_lane == RATE)
      push_beat();
    if (m_nbeats == BURST_LEN)
      push_burst();
    if (last)
      close_burst();
    m_started = !last;
    m_prev    = addr;
  endtask

  task automatic write_word(input logic [IMGSIZE-1:0] addr, input logic [DWIDTH-1:0] data,
                            input bit last);
    @(negedge clk);
    while (!mem_ready) begin
      saw_stall = 1'b1;
      @(posedge clk);
      mem_we <= 1'b0;
      @(negedge clk);
    end
    @(posedge clk);
    mem_we    <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= data;
    model_word(addr, data, last);
  endtask

  task automatic write_run(input logic [IMGSIZE-1:0] start, input int count, input bit ends_job);
    for (int i = 0; i < count; i++) begin
      write_word(start + IMGSIZE'(i), DWIDTH'($urandom), ends_job && i == count - 1);
    end
  endtask

  task automatic start_job(input int words);
    @(posedge clk);
    total_len <= LWIDTH'(words);
  endtask

  // Stop writing and let the master empty both buffers.
  task automatic finish_job();
    @(posedge clk);
    mem_we <= 1'b0;
    @(negedge clk);
    while (exp_len.size() != 0 || draining)
      @(negedge clk);
  endtask

  task automatic drain_burst();
    logic [IMGSIZE-1:0] base;
    logic [LENW-1:0]    len;
    logic [BWIDTH-1:0]  beat;
    if (exp_len.size() == 0) begin
      $display("Unexpected DDR request at time %0t with no burst left to drain.", $time);
      abort_run();
    end else begin
      draining = 1'b1;
      base     = exp_base.pop_front();
      len      = exp_len.pop_front();
      assert (ddr_len == len) else report_mismatch("ddr_len", BWIDTH'(len), BWIDTH'(ddr_len));
      assert (ddr_base == base)
        else report_mismatch("ddr_base", BWIDTH'(base), BWIDTH'(ddr_base));
      for (int k = 0; k < int'(len); k++) begin
        repeat ($urandom % 21) @(posedge clk);
        @(posedge clk);
        ddr_re   <= 1'b1;
        ddr_addr <= AWIDTH'(k);
        @(posedge clk);
        ddr_re <= 1'b0;
        @(negedge clk);  // Read data of the beat is valid now.
        beat = exp_beats.pop_front();
        assert (ddr_wdata == beat) else report_mismatch("ddr_wdata", beat, ddr_wdata);
      end
      draining = 1'b0;
    end
  endtask

  initial begin : ddr_master
    forever begin
      if (ddr_req)
        drain_burst();
      else
        @(negedge clk);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DDR drains did not finish.", cycles);
      abort_run();
    end
  end

  initial begin : stimulus
    xrst      = 1'b0;
    total_len = '0;
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    ddr_re    = 1'b0;
    ddr_addr  = '0;
    void'($urandom(32'h43ad_03c2));
    repeat (10) @(posedge clk);
    xrst <= 1'b1;

    start_job(FULL_RUN);  // Two full bursts.
    write_run(IMGSIZE'('h100), FULL_RUN, 1'b1);
    finish_job();

    start_job(JUMP_A + JUMP_B);  // Jump in the middle of a beat.
    write_run(IMGSIZE'('h200), JUMP_A, 1'b0);
    write_run(IMGSIZE'('h340), JUMP_B, 1'b1);
    finish_job();

    start_job(FULL_RUN + TAIL_RUN);  // Job ends inside a burst.
    write_run(IMGSIZE'('h500), FULL_RUN, 1'b0);
    write_run(IMGSIZE'('h700), TAIL_RUN, 1'b1);
    finish_job();

    repeat (4 * BURST_LEN) @(posedge clk);  // No request may follow.
    if (!saw_stall) begin
      $display("mem_ready never went low, so back-pressure was not exercised.");
      abort_run();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
ninjin_pkg.sv
mem_sp.sv
ninjin_pack.sv
ninjin_ddr_buf.sv
ninjin_top.sv
tb_ninjin_asserts.sv
tb_ninjin.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_ninjin -f sources.f -o tb_ninjin || exit 1
out=$(./obj_dir/tb_ninjin 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
